// File: pix_cfg.svh
`ifndef PIX_CFG_SVH
`define PIX_CFG_SVH

// ------------------------------
// Stream geometry
// ------------------------------
`define PIX_WORD_WIDTH   8
`define PIX_S_WORDS      4                                     // Words per input beat
`define PIX_ROWS         4
`define PIX_KH_MAX       3
`define PIX_KW_MAX       3
`define PIX_SH_MAX       2
`define PIX_M_WORDS      (`PIX_ROWS + `PIX_KH_MAX - 1)          // Widest output beat
`define PIX_BUF_WORDS    (`PIX_S_WORDS + `PIX_M_WORDS - 1)

// ------------------------------
// Derived field widths
// ------------------------------
`define PIX_BITS_WORDS   $clog2(`PIX_M_WORDS + 1)
`define PIX_BITS_KH2     $clog2(`PIX_KH_MAX / 2 + 1)
`define PIX_BITS_KW2     $clog2(`PIX_KW_MAX / 2 + 1)
`define PIX_BITS_SH      $clog2(`PIX_SH_MAX)
`define PIX_BITS_SHIFT   $clog2(`PIX_KH_MAX)                    // Holds KH_MAX - 1
`define PIX_BITS_FILL    $clog2(`PIX_BUF_WORDS + 1)
`define PIX_BEAT_WIDTH   (`PIX_S_WORDS * `PIX_WORD_WIDTH)
`define PIX_OUTPUT_CONV  0                                     // 1 drops lrelu support

`endif

// File: pix_cfg_pkg.sv
`include "pix_cfg.svh"

package pix_cfg_pkg;

  localparam int CFG_BITS = `PIX_BITS_WORDS + `PIX_BITS_SH + `PIX_BITS_KW2
                          + `PIX_BITS_KH2 + 3;

  typedef logic [`PIX_WORD_WIDTH-1:0] word_t;
  typedef word_t [`PIX_S_WORDS-1:0]   s_words_t;

  // ------------------------------
  // Config word, first beat of an image
  // ------------------------------
  typedef struct packed {
    logic [`PIX_BEAT_WIDTH-CFG_BITS-1:0] pad;         // Zero
    logic [`PIX_BITS_WORDS-1:0]          words;       // Output word count
    logic [`PIX_BITS_SH-1:0]             sh_1;        // Stride minus one
    logic [`PIX_BITS_KW2-1:0]            kw2;
    logic [`PIX_BITS_KH2-1:0]            kh2;         // Kernel height is 2*kh2+1
    logic                                is_lrelu;
    logic                                is_max;
    logic                                is_not_max;
  } cfg_fields_t;

  // Same bits are config in SET and pixels afterwards
  typedef union packed {
    s_words_t    pix;
    cfg_fields_t cfg;
  } beat_u;

  typedef struct packed {
    logic is_not_max;
    logic is_max;
    logic is_lrelu;
  } user_t;

endpackage

// File: pix_stream_pkg.sv
`include "pix_cfg.svh"

package pix_stream_pkg;

  typedef pix_cfg_pkg::word_t [`PIX_M_WORDS-1:0] m_words_t;

  // ------------------------------
  // Input side, from the DMA
  // ------------------------------
  typedef struct packed {
    pix_cfg_pkg::beat_u      data;
    logic [`PIX_S_WORDS-1:0] keep;                    // One bit per word
    logic                    last;
  } s_beat_t;

  // ------------------------------
  // Output side, to the engine
  // ------------------------------
  typedef struct packed {
    m_words_t                   data;
    logic [`PIX_BITS_SHIFT-1:0] shift;
    logic                       ones;                 // Ones beat marker
    logic                       last;
    pix_cfg_pkg::user_t         user;
  } m_beat_t;

endpackage

// File: pix_shift_gen.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module pix_shift_gen (
  input  logic                       aclk,
  input  logic                       i_rst,
  input  logic                       i_clear,
  input  logic                       i_step,
  input  logic [`PIX_BITS_KH2-1:0]   i_kh2,
  input  logic [`PIX_BITS_SH-1:0]    i_sh_1,
  output logic [`PIX_BITS_SHIFT-1:0] o_shift
);

  localparam int KH2_N   = `PIX_KH_MAX / 2 + 1;
  localparam int SH_N    = `PIX_SH_MAX;
  localparam int SHIFT_W = `PIX_BITS_SHIFT;

  logic [`PIX_BITS_SH-1:0] count_sh;
  logic                    count_last;
  logic [SHIFT_W-1:0]      lut_general [KH2_N][SH_N];
  logic [SHIFT_W-1:0]      lut_last    [KH2_N][SH_N];

  // ------------------------------
  // Kernel/stride lookup
  // ------------------------------
  for (genvar g_kh2 = 0; g_kh2 < KH2_N; g_kh2++) begin : g_kh
    for (genvar g_sh = 0; g_sh < SH_N; g_sh++) begin : g_st
      localparam int K          = 2 * g_kh2 + 1;
      localparam int S          = g_sh + 1;
      localparam int SHIFT_GEN  = (K + S - 1) / S - 1;              // ceil(k/s) - 1
      localparam int SHIFT_LAST = (K / S > 0) ? K / S - 1 : 0;      // No overlap when k < s
      assign lut_general[g_kh2][g_sh] = SHIFT_W'(SHIFT_GEN);
      assign lut_last[g_kh2][g_sh]    = SHIFT_W'(SHIFT_LAST);
    end
  end

  // ------------------------------
  // Stride counter
  // ------------------------------
  assign count_last = count_sh == i_sh_1;

  always_ff @(posedge aclk) begin
    if (i_rst || i_clear) begin
      count_sh <= '0;
    end else if (i_step) begin
      count_sh <= count_last ? '0 : count_sh + 1'b1;
    end
  end

  assign o_shift = count_last ? lut_last[i_kh2][i_sh_1] : lut_general[i_kh2][i_sh_1];

endmodule

// File: pix_repack.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module pix_repack (
  input  logic                       aclk,
  input  logic                       i_rst,
  input  logic [`PIX_BITS_WORDS-1:0] i_words,
  input  logic                       i_valid,
  input  pix_cfg_pkg::s_words_t      i_data,
  input  logic [`PIX_S_WORDS-1:0]    i_keep,
  input  logic                       i_last,
  input  logic                       i_ready,
  output logic                       o_ready,
  output logic                       o_valid,
  output pix_stream_pkg::m_words_t   o_data,
  output logic                       o_last
);

  localparam int BUF_N  = `PIX_BUF_WORDS;
  localparam int S_N    = `PIX_S_WORDS;
  localparam int M_N    = `PIX_M_WORDS;
  localparam int FILL_W = `PIX_BITS_FILL;

  pix_cfg_pkg::word_t mem_q [BUF_N];
  pix_cfg_pkg::word_t mem_d [BUF_N];
  pix_cfg_pkg::word_t kept  [S_N];

  logic [FILL_W-1:0] fill, fill_d, kept_cnt, out_n, words;
  logic              last_seen, in_fire, out_fire;

  // ------------------------------
  // Handshake
  // ------------------------------
  assign words    = FILL_W'(i_words);
  assign o_ready  = ~last_seen & (fill <= FILL_W'(BUF_N - S_N));   // Room for a full beat
  assign o_valid  = last_seen | ((fill >= words) & (words != '0));
  assign o_last   = last_seen & (fill <= words);                   // Drains the buffer
  assign in_fire  = i_valid & o_ready;
  assign out_fire = o_valid & i_ready;
  assign out_n    = out_fire ? ((fill < words) ? fill : words) : '0;

  // Squeeze out the words whose keep bit is low
  always_comb begin
    int n;
    n = 0;
    for (int i = 0; i < S_N; i++) begin
      kept[i] = '0;
    end
    for (int i = 0; i < S_N; i++) begin
      if (i_keep[i]) begin
        kept[n] = i_data[i];
        n++;
      end
    end
    kept_cnt = FILL_W'(n);
  end

  // ------------------------------
  // Buffer update
  // ------------------------------
  always_comb begin
    int base;
    int drop;
    base   = int'(fill - out_n);
    drop   = int'(out_n);
    fill_d = fill - out_n + (in_fire ? kept_cnt : FILL_W'(0));
    for (int j = 0; j < BUF_N; j++) begin
      if (j + drop < BUF_N) begin
        mem_d[j] = mem_q[j + drop];                          // Shift out the sent words
      end else begin
        mem_d[j] = '0;
      end
      if (in_fire && (j >= base) && (j < base + int'(kept_cnt))) begin
        mem_d[j] = kept[j - base];                           // Append behind the remainder
      end
    end
  end

  always_ff @(posedge aclk) begin
    mem_q <= mem_d;
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      fill      <= '0;
      last_seen <= 1'b0;
    end else begin
      fill <= fill_d;
      if (out_fire && o_last) begin
        last_seen <= 1'b0;
      end else if (in_fire && i_last) begin
        last_seen <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Output words
  // ------------------------------
  // An image whose last beat keeps nothing and leaves the buffer empty still
  // gets one all-zero beat carrying last
  always_comb begin
    for (int j = 0; j < M_N; j++) begin
      if ((FILL_W'(j) < words) && (FILL_W'(j) < fill)) begin
        o_data[j] = mem_q[j];
      end else begin
        o_data[j] = '0;                                      // Pad and unused words
      end
    end
  end

endmodule

// File: pix_dw_ctrl.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module pix_dw_ctrl (
  input  logic                       aclk,
  input  logic                       i_rst,
  input  logic                       i_s_valid,
  input  pix_stream_pkg::s_beat_t    i_s_beat,
  input  logic                       i_m_ready,
  input  logic                       i_pk_s_ready,
  input  logic                       i_pk_m_valid,
  input  logic                       i_pk_m_last,
  input  pix_stream_pkg::m_words_t   i_pk_data,
  input  logic [`PIX_BITS_SHIFT-1:0] i_shift,
  output logic                       o_s_ready,
  output logic                       o_m_valid,
  output pix_stream_pkg::m_beat_t    o_m_beat,
  output logic                       o_in_en,
  output logic                       o_out_en,
  output logic                       o_out_beat,
  output logic                       o_clear,
  output pix_cfg_pkg::cfg_fields_t   o_cfg
);

  typedef enum logic [1:0] {S_SET, S_ONES, S_PASS, S_BLOCK} state_t;

  state_t state, state_next;
  logic   s_beat, s_last_beat, pk_last_beat, in_done, in_open;

  assign s_beat       = i_s_valid & o_s_ready;
  assign s_last_beat  = s_beat & i_s_beat.last & (state != S_SET);
  assign pk_last_beat = o_out_beat & i_pk_m_last;
  assign in_open      = ((state == S_ONES) | (state == S_PASS)) & ~in_done;
  assign o_in_en      = i_s_valid & in_open;                  // Packer input valid
  assign o_out_en     = i_m_ready & ((state == S_PASS) | (state == S_BLOCK));
  assign o_out_beat   = o_out_en & i_pk_m_valid;              // Pass beat taken
  assign o_clear      = state == S_SET;

  // ------------------------------
  // State machine
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      S_SET:   if (s_beat) state_next = S_ONES;
      S_ONES:  if (i_m_ready) state_next = (in_done | s_last_beat) ? S_BLOCK : S_PASS;
      S_PASS:  if (s_last_beat) state_next = pk_last_beat ? S_SET : S_BLOCK;
      S_BLOCK: if (pk_last_beat) state_next = S_SET;
      default: state_next = S_SET;
    endcase
  end

  always_comb begin
    o_s_ready = 1'b0;
    o_m_valid = 1'b0;
    case (state)
      S_SET:   o_s_ready = 1'b1;
      S_ONES: begin
        o_s_ready = i_pk_s_ready & in_open;
        o_m_valid = 1'b1;
      end
      default: begin
        o_s_ready = i_pk_s_ready & in_open;                  // Zero in BLOCK
        o_m_valid = i_pk_m_valid;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state   <= S_SET;
      in_done <= 1'b0;
      o_cfg   <= '0;
    end else begin
      state <= state_next;
      if (state == S_SET) in_done <= 1'b0;
      else if (s_last_beat) in_done <= 1'b1;                 // Image may end during ONES
      if ((state == S_SET) && s_beat) o_cfg <= i_s_beat.data.cfg;
    end
  end

  // ------------------------------
  // Output beat
  // ------------------------------
  always_comb begin
    o_m_beat.data            = i_pk_data;
    o_m_beat.shift           = i_shift;
    o_m_beat.ones            = 1'b0;
    o_m_beat.last            = i_pk_m_last;
    o_m_beat.user.is_not_max = o_cfg.is_not_max;
    o_m_beat.user.is_max     = o_cfg.is_max;
    o_m_beat.user.is_lrelu   = o_cfg.is_lrelu & (`PIX_OUTPUT_CONV == 0);
    if (state == S_ONES) begin
      o_m_beat.data    = '0;
      o_m_beat.data[0] = pix_cfg_pkg::word_t'(1);
      o_m_beat.shift   = '0;
      o_m_beat.ones    = 1'b1;
      o_m_beat.last    = 1'b0;
    end
  end

endmodule

// File: pix_dw_top.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module pix_dw_top (
  input  logic                    aclk,
  input  logic                    i_rst,
  input  logic                    i_s_valid,
  input  pix_stream_pkg::s_beat_t i_s_beat,
  output logic                    o_s_ready,
  output logic                    o_m_valid,
  output pix_stream_pkg::m_beat_t o_m_beat,
  input  logic                    i_m_ready
);

  logic                       in_en, out_en, out_beat, clear;
  logic                       pk_s_ready, pk_m_valid, pk_m_last;
  logic [`PIX_BITS_SHIFT-1:0] shift;
  pix_stream_pkg::m_words_t   pk_data;
  pix_cfg_pkg::cfg_fields_t   cfg;

  pix_dw_ctrl u_pix_dw_ctrl (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_s_valid    (i_s_valid),
    .i_s_beat     (i_s_beat),
    .i_m_ready    (i_m_ready),
    .i_pk_s_ready (pk_s_ready),
    .i_pk_m_valid (pk_m_valid),
    .i_pk_m_last  (pk_m_last),
    .i_pk_data    (pk_data),
    .i_shift      (shift),
    .o_s_ready    (o_s_ready),
    .o_m_valid    (o_m_valid),
    .o_m_beat     (o_m_beat),
    .o_in_en      (in_en),
    .o_out_en     (out_en),
    .o_out_beat   (out_beat),
    .o_clear      (clear),
    .o_cfg        (cfg)
  );

  pix_repack u_pix_repack (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_words (cfg.words),
    .i_valid (in_en),                                        // Already gated by phase
    .i_data  (i_s_beat.data.pix),
    .i_keep  (i_s_beat.keep),
    .i_last  (i_s_beat.last),
    .i_ready (out_en),
    .o_ready (pk_s_ready),
    .o_valid (pk_m_valid),
    .o_data  (pk_data),
    .o_last  (pk_m_last)
  );

  pix_shift_gen u_pix_shift_gen (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_clear (clear),
    .i_step  (out_beat),
    .i_kh2   (cfg.kh2),
    .i_sh_1  (cfg.sh_1),
    .o_shift (shift)
  );

endmodule

// File: pix_dw_chk.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module pix_dw_chk (
  input logic                    aclk,
  input logic                    i_rst,
  input logic                    i_s_valid,
  input pix_stream_pkg::s_beat_t i_s_beat,
  input logic                    o_s_ready,
  input logic                    o_m_valid,
  input pix_stream_pkg::m_beat_t o_m_beat,
  input logic                    i_m_ready
);

  int   fail_count = 0;
  logic cfg_next, blocked, s_fire, m_fire_last;

  assign s_fire      = i_s_valid & o_s_ready;
  assign m_fire_last = o_m_valid & i_m_ready & o_m_beat.last & ~o_m_beat.ones;

  // From the input's last beat until the output's last beat
  always_ff @(posedge aclk) begin
    if (i_rst) begin
      cfg_next <= 1'b1;
      blocked  <= 1'b0;
    end else if (m_fire_last) begin
      cfg_next <= 1'b1;
      blocked  <= 1'b0;
    end else if (s_fire && cfg_next) begin
      cfg_next <= 1'b0;
    end else if (s_fire && i_s_beat.last) begin
      blocked <= 1'b1;
    end
  end

  // ------------------------------
  a_reset_idle: assert property (@(posedge aclk) i_rst |=> (!o_m_valid && o_s_ready))
    else begin
      $error("ports not idle after reset");
      fail_count++;
    end

  a_hold_beat: assert property (@(posedge aclk) disable iff (i_rst)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_beat)))
    else begin
      $error("output beat changed while stalled");
      fail_count++;
    end

  a_block_input: assert property (@(posedge aclk) disable iff (i_rst) blocked |-> !o_s_ready)
    else begin
      $error("input ready while draining the image");
      fail_count++;
    end

  a_ones_beat: assert property (@(posedge aclk) disable iff (i_rst)
    (o_m_valid && o_m_beat.ones) |-> ((o_m_beat.shift == '0) && !o_m_beat.last))
    else begin
      $error("ones beat with nonzero shift or last");
      fail_count++;
    end

endmodule

bind pix_dw_top pix_dw_chk u_pix_dw_chk (.*);

// File: tb_pix_dw.sv
`timescale 1ns/1ps
`include "pix_cfg.svh"

module tb_pix_dw;

  localparam int N_IMG   = 5;
  localparam int T_LIMIT = 3000;                               // Cycles allowed per image

  logic                    aclk, i_rst, i_s_valid, i_m_ready, o_s_ready, o_m_valid;
  pix_stream_pkg::s_beat_t i_s_beat;
  pix_stream_pkg::m_beat_t o_m_beat;

  logic [31:0] rng;
  int          errors, n_pass, n_fail;
  logic        timed_out;
  int          img_words [N_IMG] = '{4, 5, 6, 6, 5};
  int          img_sh_1  [N_IMG] = '{0, 1, 0, 1, 1};
  int          img_kh2   [N_IMG] = '{0, 1, 1, 1, 0};

  pix_stream_pkg::s_beat_t s_q[$];                             // Beats still to send
  pix_stream_pkg::m_beat_t m_q[$];                             // Expected output beats

  pix_dw_top u_pix_dw_top (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .i_s_beat  (i_s_beat),
    .o_s_ready (o_s_ready),
    .o_m_valid (o_m_valid),
    .o_m_beat  (o_m_beat),
    .i_m_ready (i_m_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng >> 8;
  endfunction

  // Overlap rows for kernel 2*kh2+1 at stride sh_1+1
  function automatic logic [`PIX_BITS_SHIFT-1:0] expect_shift(int kh2, int sh_1, int cnt);
    int k;
    int s;
    int v;
    k = 2 * kh2 + 1;
    s = sh_1 + 1;
    v = (cnt == sh_1) ? k / s - 1 : (k + s - 1) / s - 1;
    if (v < 0) v = 0;
    return v[`PIX_BITS_SHIFT-1:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (exp == got) else begin
      $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic compare_beat(input pix_stream_pkg::m_beat_t exp);
    check_value("o_m_beat.data", 64'(exp.data), 64'(o_m_beat.data));
    check_value("o_m_beat.shift", 64'(exp.shift), 64'(o_m_beat.shift));
    check_value("o_m_beat.ones", 64'(exp.ones), 64'(o_m_beat.ones));
    check_value("o_m_beat.last", 64'(exp.last), 64'(o_m_beat.last));
    check_value("o_m_beat.user", 64'(exp.user), 64'(o_m_beat.user));
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic build_image(input int n_words, input int sh_1, input int kh2, input int n_beats);
    pix_cfg_pkg::cfg_fields_t cfg;
    pix_cfg_pkg::user_t       user;
    pix_stream_pkg::s_beat_t  sb;
    pix_stream_pkg::m_beat_t  mb;
    pix_cfg_pkg::word_t       words_q[$];
    logic [31:0]              r;
    int                       cnt;
    r              = next_rand();
    cfg            = '0;
    cfg.words      = 3'(n_words);
    cfg.sh_1       = 1'(sh_1);
    cfg.kh2        = 1'(kh2);
    cfg.kw2        = 1'(kh2);
    {cfg.is_lrelu, cfg.is_max, cfg.is_not_max} = r[2:0];
    sb.data.cfg    = cfg;
    sb.keep        = '1;
    sb.last        = 1'b0;
    s_q.push_back(sb);
    user.is_not_max = cfg.is_not_max;
    user.is_max     = cfg.is_max;
    user.is_lrelu   = cfg.is_lrelu & (`PIX_OUTPUT_CONV == 0);
    mb              = '0;
    mb.data[0]      = 8'd1;                                    // Ones beat
    mb.ones         = 1'b1;
    mb.user         = user;
    m_q.push_back(mb);
    for (int b = 0; b < n_beats; b++) begin
      r                = next_rand();
      sb.data.pix[1:0] = r[15:0];
      r                = next_rand();
      sb.data.pix[3:2] = r[15:0];
      r                = next_rand();
      sb.keep          = r[7:4];
      sb.last          = (b == n_beats - 1);
      if (sb.last && (sb.keep == '0)) sb.keep = 4'b0001;     // Final beat carries a word
      s_q.push_back(sb);
      for (int i = 0; i < `PIX_S_WORDS; i++) begin
        if (sb.keep[i]) words_q.push_back(sb.data.pix[i]);
      end
    end
    cnt = 0;
    while (words_q.size() > 0) begin
      mb = '0;
      for (int j = 0; j < n_words; j++) begin
        if (words_q.size() > 0) mb.data[j] = words_q.pop_front();
      end
      mb.shift = expect_shift(kh2, sh_1, cnt);
      mb.last  = (words_q.size() == 0);
      mb.user  = user;
      m_q.push_back(mb);
      cnt = (cnt == sh_1) ? 0 : cnt + 1;
    end
  endtask

  // ------------------------------
  // Stream driver and monitor
  // ------------------------------
  task automatic run_image(input int idx);
    int          cycles;
    int          errs_before;
    logic        s_taken;
    logic [31:0] r;
    cycles      = 0;
    errs_before = errors;
    s_taken     = 1'b0;
    while ((s_q.size() > 0 || m_q.size() > 0) && cycles < T_LIMIT) begin
      @(negedge aclk);
      if (s_taken) i_s_valid = 1'b0;
      s_taken = 1'b0;
      r = next_rand();
      if (!i_s_valid && (s_q.size() > 0) && (r[1:0] != 2'd0)) begin
        i_s_valid = 1'b1;
        i_s_beat  = s_q[0];
      end
      i_m_ready = (r[4:3] != 2'd0);
      #1;                                                      // Outputs settled until posedge
      if (i_s_valid && o_s_ready) begin
        void'(s_q.pop_front());
        s_taken = 1'b1;
      end
      if (o_m_valid && i_m_ready) begin
        assert (m_q.size() > 0) else begin
          $display("output beat taken at %0t when no more beats were expected", $time);
          errors++;
        end
        if (m_q.size() > 0) begin
          compare_beat(m_q[0]);
          void'(m_q.pop_front());
        end
      end
      cycles++;
    end
    if ((s_q.size() > 0) || (m_q.size() > 0)) begin
      $display("timeout in image %0d: stream did not finish in %0d cycles", idx, T_LIMIT);
      timed_out = 1'b1;
      errors++;
    end
    if (errors == errs_before) n_pass++;
    else n_fail++;
    $display("image %0d words=%0d sh_1=%0d kh2=%0d: %s", idx, img_words[idx],
             img_sh_1[idx], img_kh2[idx], (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    rng       = 32'd9050;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    i_rst     = 1'b1;
    i_s_valid = 1'b0;
    i_s_beat  = '0;
    i_m_ready = 1'b0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    i_rst = 1'b0;
    for (int i = 0; i < N_IMG && !timed_out; i++) begin
      build_image(img_words[i], img_sh_1[i], img_kh2[i], 5 + 2 * i);
      run_image(i);
    end
    errors += u_pix_dw_top.u_pix_dw_chk.fail_count;
    $display("images passed=%0d failed=%0d, assertion failures=%0d", n_pass, n_fail,
             u_pix_dw_top.u_pix_dw_chk.fail_count);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
pix_cfg_pkg.sv
pix_stream_pkg.sv
pix_shift_gen.sv
pix_repack.sv
pix_dw_ctrl.sv
pix_dw_top.sv
pix_dw_chk.sv
tb_pix_dw.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_pix_dw
FILELIST  = verilog.f
BUILD     = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
